// File: rtl/wallacePkg.sv
package wallacePkg;

	// Radix-4 Booth layout for a 24x24 product
	localparam int unsigned rowCount = 13;
	localparam int unsigned rowWidth = 26;
	localparam int unsigned rowShift = 2;
	localparam int unsigned productWidth = 48;

	// Row counts after each 3:2 layer
	localparam int unsigned firstLayerRows = 9;
	localparam int unsigned earlyRows = 6;
	localparam int unsigned thirdLayerRows = 4;
	localparam int unsigned fourthLayerRows = 3;

	// Input to product, in clock cycles
	localparam int unsigned pipeDepth = 3;

	typedef logic signed [rowWidth-1:0] rowT;
	typedef rowT [rowCount-1:0] rowArrayT;
	typedef logic [productWidth-1:0] sumT;
	typedef sumT [earlyRows-1:0] earlyArrayT;

	// Sign-extend a row and move it to weight 4**index
	function automatic sumT alignRow(rowT row, int unsigned index);
		sumT extended;
		extended = {{(productWidth - rowWidth){row[rowWidth-1]}}, row};
		return extended << (rowShift * index);
	endfunction

	// Full adder per bit position
	function automatic sumT csaSum(sumT a, sumT b, sumT c);
		return a ^ b ^ c;
	endfunction

	// Majority moves up one weight, bit 47 carry falls off
	function automatic sumT csaCarry(sumT a, sumT b, sumT c);
		sumT majority;
		majority = (a & b) | (a & c) | (b & c);
		return majority << 1;
	endfunction

endpackage

// File: rtl/earlyReducer.sv
`timescale 1ns/1ps

module earlyReducer
	import wallacePkg::*;
(
	input logic clk,
	input logic rstN,
	input rowArrayT rows,
	input logic inValid,
	output earlyArrayT earlyRowsQ,
	output logic earlyValid
);

	sumT aligned [rowCount];
	sumT layer1 [firstLayerRows];
	sumT layer2 [earlyRows];

	genvar k;
	genvar g;

	// Rows at their weights with the upper bits filled by the sign
	generate
		for (k = 0; k < rowCount; k++) begin : genAlign
			assign aligned[k] = alignRow(rows[k], k);
		end
	endgenerate

	// Layer 1 takes thirteen rows down to nine
	generate
		for (g = 0; g < rowCount / 3; g++) begin : genLayer1
			assign layer1[2*g] = csaSum(
				aligned[3*g],
				aligned[3*g+1],
				aligned[3*g+2]
			);
			assign layer1[2*g+1] = csaCarry(
				aligned[3*g],
				aligned[3*g+1],
				aligned[3*g+2]
			);
		end

		// Leftover row goes straight through
		for (k = 3 * (rowCount / 3); k < rowCount; k++) begin : genPass1
			assign layer1[k - rowCount / 3] = aligned[k];
		end
	endgenerate

	// Layer 2 takes nine rows down to six
	generate
		for (g = 0; g < firstLayerRows / 3; g++) begin : genLayer2
			assign layer2[2*g] = csaSum(
				layer1[3*g],
				layer1[3*g+1],
				layer1[3*g+2]
			);
			assign layer2[2*g+1] = csaCarry(
				layer1[3*g],
				layer1[3*g+1],
				layer1[3*g+2]
			);
		end
	endgenerate

	// Six rows into the stage register
	always_ff @(posedge clk) begin
		for (int i = 0; i < earlyRows; i++) begin
			earlyRowsQ[i] <= layer2[i];
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			earlyValid <= 1'b0;
		end else begin
			earlyValid <= inValid;
		end
	end

	// A floating strobe upstream would poison every later stage
	earlyValidKnown: assert property (
		@(posedge clk) disable iff (!rstN)
		!$isunknown(earlyValid)
	) else $error("earlyValid is unknown out of reset");

endmodule

// File: rtl/lateReducer.sv
`timescale 1ns/1ps

module lateReducer
	import wallacePkg::*;
(
	input logic clk,
	input logic rstN,
	input earlyArrayT earlyRowsQ,
	input logic earlyValid,
	output sumT sumQ,
	output sumT carryQ,
	output logic pairValid
);

	sumT layer3 [thirdLayerRows];
	sumT layer4 [fourthLayerRows];
	sumT pairSum;
	sumT pairCarry;

	genvar g;
	genvar k;

	// Layer 3, six rows down to four
	generate
		for (g = 0; g < earlyRows / 3; g++) begin : genLayer3
			assign layer3[2*g] = csaSum(
				earlyRowsQ[3*g],
				earlyRowsQ[3*g+1],
				earlyRowsQ[3*g+2]
			);
			assign layer3[2*g+1] = csaCarry(
				earlyRowsQ[3*g],
				earlyRowsQ[3*g+1],
				earlyRowsQ[3*g+2]
			);
		end
	endgenerate

	// Layer 4, four rows down to three
	generate
		for (g = 0; g < thirdLayerRows / 3; g++) begin : genLayer4
			assign layer4[2*g] = csaSum(
				layer3[3*g],
				layer3[3*g+1],
				layer3[3*g+2]
			);
			assign layer4[2*g+1] = csaCarry(
				layer3[3*g],
				layer3[3*g+1],
				layer3[3*g+2]
			);
		end

		// Fourth row waits one layer
		for (k = 3 * (thirdLayerRows / 3); k < thirdLayerRows; k++) begin : genPass4
			assign layer4[k - thirdLayerRows / 3] = layer3[k];
		end
	endgenerate

	// Layer 5 leaves the carry-save pair
	assign pairSum = csaSum(layer4[0], layer4[1], layer4[2]);
	assign pairCarry = csaCarry(layer4[0], layer4[1], layer4[2]);

	always_ff @(posedge clk) begin
		sumQ <= pairSum;
		carryQ <= pairCarry;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pairValid <= 1'b0;
		end else begin
			pairValid <= earlyValid;
		end
	end

	// Strobe keeps step with the data through this stage
	pairValidFollows: assert property (
		@(posedge clk) disable iff (!rstN)
		$past(rstN) |-> (pairValid == $past(earlyValid))
	) else $error("pairValid does not follow earlyValid by one cycle");

endmodule

// File: rtl/finalAdder.sv
`timescale 1ns/1ps

module finalAdder
	import wallacePkg::*;
(
	input logic clk,
	input logic rstN,
	input sumT sumQ,
	input sumT carryQ,
	input logic pairValid,
	output sumT product,
	output logic outValid
);

	sumT fullSum;

	// Carry-propagate add, result wraps at 2**48
	assign fullSum = sumQ + carryQ;

	always_ff @(posedge clk) begin
		product <= fullSum;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= pairValid;
		end
	end

	// No product appears without a pair behind it
	outValidHasSource: assert property (
		@(posedge clk) disable iff (!rstN)
		$rose(outValid) |-> $past(pairValid)
	) else $error("outValid rose without pairValid one cycle earlier");

endmodule

// File: rtl/wallaceTree.sv
`timescale 1ns/1ps

module wallaceTree
	import wallacePkg::*;
(
	input logic clk,
	input logic rstN,
	input rowArrayT rows,
	input logic inValid,
	output sumT product,
	output logic outValid
);

	// Six aligned rows between the reducers
	earlyArrayT earlyRowsQ;
	logic earlyValid;

	// Carry-save pair into the final adder
	sumT sumQ;
	sumT carryQ;
	logic pairValid;

	earlyReducer uEarly (
		.clk(clk),
		.rstN(rstN),
		.rows(rows),
		.inValid(inValid),
		.earlyRowsQ(earlyRowsQ),
		.earlyValid(earlyValid)
	);

	lateReducer uLate (
		.clk(clk),
		.rstN(rstN),
		.earlyRowsQ(earlyRowsQ),
		.earlyValid(earlyValid),
		.sumQ(sumQ),
		.carryQ(carryQ),
		.pairValid(pairValid)
	);

	finalAdder uFinal (
		.clk(clk),
		.rstN(rstN),
		.sumQ(sumQ),
		.carryQ(carryQ),
		.pairValid(pairValid),
		.product(product),
		.outValid(outValid)
	);

endmodule

// File: tests/wallaceTreeTb.sv
`timescale 1ns/1ps

module wallaceTreeTb
	import wallacePkg::*;
();

	localparam int unsigned fieldsPerVector = rowCount + 1;
	localparam int unsigned maxVectors = 64;
	localparam int unsigned resetCycles = 4;
	localparam int unsigned idleCycles = 6;
	localparam int unsigned signCases = 4;
	localparam int unsigned burstCount = 200;
	localparam int unsigned streamCycles = 300;
	localparam int unsigned tailCycles = 4;
	localparam int unsigned timeoutMargin = 20;

	logic clk = 1'b0;
	logic rstN;
	rowArrayT rows;
	logic inValid;
	sumT product;
	logic outValid;

	// Thirteen rows then the expected sum for each vector
	logic [productWidth-1:0] vectorMem [maxVectors*fieldsPerVector];
	int unsigned vectorCount;

	// Products in flight and the cycle each one is due
	sumT expectedQ [$];
	int unsigned dueQ [$];

	int unsigned cycleCount;
	int unsigned cycleLimit;
	int unsigned valueErrors;
	int unsigned protocolErrors;
	logic [31:0] lcgState;

	wallaceTree DUT (
		.clk(clk),
		.rstN(rstN),
		.rows(rows),
		.inValid(inValid),
		.product(product),
		.outValid(outValid)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	// Upper LCG bits are the better ones
	function automatic rowT randomRow();
		logic [31:0] r;
		r = nextRand();
		return r[31:6];
	endfunction

	function automatic rowArrayT randomRows();
		rowArrayT value;
		for (int k = 0; k < rowCount; k++) begin
			value[k] = randomRow();
		end
		return value;
	endfunction

	// Sign-extended rows times 4**k summed modulo 2**48
	function automatic sumT modelSum(rowArrayT r);
		sumT acc;
		sumT extended;
		sumT weight;
		acc = '0;
		for (int k = 0; k < rowCount; k++) begin
			extended = {{(productWidth - rowWidth){r[k][rowWidth-1]}}, r[k]};
			weight = sumT'(1) << (rowShift * k);
			acc = acc + extended * weight;
		end
		return acc;
	endfunction

	task automatic finishRun();
		$display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	endtask

	task automatic loadVectors();
		vectorCount = 0;
		$readmemh("tests/wallaceVectors.txt", vectorMem);
		while (vectorCount < maxVectors
				&& !$isunknown(vectorMem[vectorCount * fieldsPerVector])) begin
			vectorCount++;
		end
		if (vectorCount == 0) begin
			$display("No vectors could be read from tests/wallaceVectors.txt");
			protocolErrors++;
		end
	endtask

	task automatic checkOutputs();
		sumT expected;
		int unsigned due;
		if (!rstN) begin
			if (outValid !== 1'b0) begin
				$display("outValid is not low during reset at %0t", $time);
				protocolErrors++;
			end
		end else begin
			// Slot passed without a product
			while (dueQ.size() > 0 && dueQ[0] < cycleCount) begin
				$display("Missing outValid for the item due in cycle %0d", dueQ[0]);
				void'(dueQ.pop_front());
				void'(expectedQ.pop_front());
				protocolErrors++;
			end
			if (outValid === 1'b1) begin
				if (expectedQ.size() == 0) begin
					$display("Unexpected outValid at %0t with nothing in flight", $time);
					protocolErrors++;
				end else begin
					expected = expectedQ.pop_front();
					due = dueQ.pop_front();
					if (due != cycleCount) begin
						$display("outValid came early in cycle %0d, the item is due in cycle %0d",
							cycleCount, due);
						protocolErrors++;
					end
					if (product !== expected) begin
						$display("Fail at %0t: product %h, expected %h", $time, product, expected);
						valueErrors++;
					end
				end
			end else if (outValid !== 1'b0) begin
				$display("outValid is unknown at %0t", $time);
				protocolErrors++;
			end
		end
	endtask

	task automatic applyItem(logic valid, rowArrayT value, sumT expected);
		@(negedge clk);
		checkOutputs();
		inValid = valid;
		rows = value;
		if (valid) begin
			expectedQ.push_back(expected);
			dueQ.push_back(cycleCount + pipeDepth);
		end
	endtask

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the run did not end within %0d cycles", cycleLimit);
			protocolErrors++;
			finishRun();
		end
	end

	initial begin
		rowArrayT value;
		sumT fileSum;
		int unsigned base;
		logic valid;
		rstN = 1'b0;
		inValid = 1'b0;
		rows = '0;
		cycleCount = 0;
		cycleLimit = 1000;
		valueErrors = 0;
		protocolErrors = 0;
		lcgState = 32'd30050;

		loadVectors();
		// Every cycle that drives or waits is one applied item
		cycleLimit = resetCycles + idleCycles + vectorCount + signCases + burstCount
			+ streamCycles + tailCycles + pipeDepth + timeoutMargin;

		repeat (resetCycles) begin
			@(negedge clk);
			checkOutputs();
		end
		rstN = 1'b1;

		// Quiet pipeline while inValid is low
		repeat (idleCycles) begin
			applyItem(1'b0, randomRows(), '0);
		end

		for (int v = 0; v < vectorCount; v++) begin
			base = v * fieldsPerVector;
			for (int k = 0; k < rowCount; k++) begin
				value[k] = vectorMem[base + k][rowWidth-1:0];
			end
			fileSum = vectorMem[base + rowCount];
			if (modelSum(value) != fileSum) begin
				$display("Fail at %0t: vector %0d lists %h, model gives %h",
					$time, v, fileSum, modelSum(value));
				valueErrors++;
			end
			applyItem(1'b1, value, fileSum);
		end

		// Sign extension cases
		value = '1;
		applyItem(1'b1, value, modelSum(value));
		value = '0;
		value[rowCount-1] = 26'h2000000;
		applyItem(1'b1, value, modelSum(value));
		for (int k = 0; k < rowCount; k++) begin
			value[k] = (k % 2) ? 26'h3543211 : 26'h1234567;
		end
		applyItem(1'b1, value, modelSum(value));
		for (int k = 0; k < rowCount; k++) begin
			value[k] = (k % 2) ? 26'h1FFFFFF : 26'h2000000;
		end
		applyItem(1'b1, value, modelSum(value));

		repeat (burstCount) begin
			value = randomRows();
			applyItem(1'b1, value, modelSum(value));
		end

		// Roughly one slot in four left empty
		repeat (streamCycles) begin
			value = randomRows();
			valid = (nextRand() >> 30) != 0;
			applyItem(valid, value, modelSum(value));
		end

		while (expectedQ.size() > 0) begin
			applyItem(1'b0, randomRows(), '0);
		end
		repeat (tailCycles) begin
			applyItem(1'b0, randomRows(), '0);
		end
		finishRun();
	end

endmodule

// File: tests/wallaceVectors.txt
// Columns: row0 .. row12 as 26-bit hex (row k weighs 4**k),
// then the expected 48-bit sum in hex
// Rows are sign-extended from bit 25
0 0 0 0 0 0 0 0 0 0 0 0 0 000000000000
1 0 0 0 0 0 0 0 0 0 0 0 0 000000000001
0 1 0 0 0 0 0 0 0 0 0 0 0 000000000004
0 0 1 0 0 0 0 0 0 0 0 0 0 000000000010
0 0 0 1 0 0 0 0 0 0 0 0 0 000000000040
0 0 0 0 1 0 0 0 0 0 0 0 0 000000000100
0 0 0 0 0 1 0 0 0 0 0 0 0 000000000400
0 0 0 0 0 0 1 0 0 0 0 0 0 000000001000
0 0 0 0 0 0 0 1 0 0 0 0 0 000000004000
0 0 0 0 0 0 0 0 1 0 0 0 0 000000010000
0 0 0 0 0 0 0 0 0 1 0 0 0 000000040000
0 0 0 0 0 0 0 0 0 0 1 0 0 000000100000
0 0 0 0 0 0 0 0 0 0 0 1 0 000000400000
0 0 0 0 0 0 0 0 0 0 0 0 1 000001000000
1 1 1 1 1 1 1 1 1 1 1 1 1 000001555555
2 2 2 2 2 2 2 2 2 2 2 2 2 000002AAAAAA
3 3 3 3 3 3 3 3 3 3 3 3 3 000003FFFFFF
3FFFFFF 0 0 0 0 0 0 0 0 0 0 0 0 FFFFFFFFFFFF
0 0 0 0 0 0 0 0 0 0 0 0 3FFFFFF FFFFFF000000
1FFFFFF 0 0 0 0 0 0 0 0 0 0 0 0 000001FFFFFF
0 0 0 0 0 0 0 0 0 0 0 0 1FFFFFF FFFFFF000000
2000000 0 0 0 0 0 0 0 0 0 0 0 0 FFFFFE000000
0 0 0 0 0 0 0 0 0 0 0 0 2000000 000000000000
1 3FFFFFF 0 0 0 0 0 0 0 0 0 0 0 FFFFFFFFFFFD
3FFFFFF 3FFFFFF 0 0 0 0 0 0 0 0 0 0 0 FFFFFFFFFFFB
5 7 0 0 0 0 0 0 0 0 0 0 0 000000000021
ABC 0 0 0 0 0 0 0 0 0 0 0 0 000000000ABC
0 0 0 123 0 0 0 0 0 0 0 0 0 0000000048C0
0 0 0 0 0 0 FF 0 0 0 0 0 0 0000000FF000
0 0 0 0 0 2 0 3 0 0 0 0 0 00000000C800
0 0 0 0 0 0 0 0 0 0 0 3FFFFFF 1 000000C00000
0 1000000 0 0 0 0 0 0 0 0 0 0 0 000004000000
0 0 0 0 0 0 0 0 0 0 0 0 1000000 000000000000
0 0 0 0 0 0 0 0 0 0 0 1000000 0 400000000000
0 0 0 0 0 0 0 0 0 0 0 2000000 0 800000000000
0 0 0 0 0 0 0 0 0 0 3FFFFFE 0 0 FFFFFFE00000
0 0 3000000 0 0 0 0 0 0 0 0 0 0 FFFFF0000000
0 0 0 0 0 0 0 0 0 ABCDEF 0 0 0 02AF37BC0000
1 0 0 0 0 0 0 0 0 0 0 0 1 000001000001
2AAAAAA 0 0 0 0 0 0 0 0 0 0 0 0 FFFFFEAAAAAA
0 1555555 0 0 0 0 0 0 0 0 0 0 0 000005555554
1 1 1 1 0 0 0 0 0 0 0 0 0 000000000055

// File: tb.f
rtl/wallacePkg.sv
rtl/earlyReducer.sv
rtl/lateReducer.sv
rtl/finalAdder.sv
rtl/wallaceTree.sv
tests/wallaceTreeTb.sv

// File: Bender.yml
package:
  name: wallace_tree

sources:
  - files:
      - rtl/wallacePkg.sv
      - rtl/earlyReducer.sv
      - rtl/lateReducer.sv
      - rtl/finalAdder.sv
      - rtl/wallaceTree.sv

  - target: test
    files:
      - tests/wallaceTreeTb.sv

# Top levels: wallaceTree, testbench wallaceTreeTb
